//--- logic/proc_pkg.sv
// Shared widths, word types and CSR numbers for the core
// Opcode constants, reset PC, ALU operation and fetch state enums

package proc_pkg;

  // ----------------------------------------
  // Widths and word types
  // ----------------------------------------

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] addr_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [11:0]     csr_t;

  // First fetch address out of reset
  localparam addr_t RESET_PC = 32'h0000_0200;

  // Manager CSRs
  localparam csr_t CSR_MNGR2PROC = 12'hFC0;
  localparam csr_t CSR_PROC2MNGR = 12'h7C0;

  // ----------------------------------------
  // Major opcodes of the supported subset
  // ----------------------------------------

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // ----------------------------------------
  // Enums
  // ----------------------------------------

  // Result ops first, then the branch compares that only drive cond
  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    IREQ,
    IWAIT,
    EXEC
  } fetch_state_e;

endpackage

//--- logic/proc_alu.sv
// Combinational ALU
// Arithmetic, logic and shift results plus branch compare outcome

`timescale 1ns/1ps

module proc_alu (
  input  proc_pkg::alu_op_e op_i,
  input  proc_pkg::word_t   a_i,
  input  proc_pkg::word_t   b_i,
  output proc_pkg::word_t   result_o,
  output logic              cond_o
);

  import proc_pkg::*;

  logic       lt_s;
  logic       lt_u;
  logic       eq;
  logic [4:0] shamt;

  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;
  assign eq    = (a_i == b_i);
  assign shamt = b_i[4:0];

  // ----------------------------------------
  // Result path
  // ----------------------------------------

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_OR:     result_o = a_i | b_i;
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SLT:    result_o = {31'b0, lt_s};
      ALU_SLTU:   result_o = {31'b0, lt_u};
      ALU_SLL:    result_o = a_i << shamt;
      ALU_SRL:    result_o = a_i >> shamt;
      ALU_SRA:    result_o = word_t'($signed(a_i) >>> shamt);
      ALU_PASS_B: result_o = b_i;
      default:    result_o = {31'b0, cond_o};
    endcase
  end

  // ----------------------------------------
  // Branch conditions
  // ----------------------------------------

  always_comb begin
    case (op_i)
      ALU_EQ:  cond_o = eq;
      ALU_NE:  cond_o = !eq;
      ALU_LT:  cond_o = lt_s;
      ALU_GE:  cond_o = !lt_s;
      ALU_LTU: cond_o = lt_u;
      ALU_GEU: cond_o = !lt_u;
      default: cond_o = 1'b0;
    endcase
  end

endmodule

//--- logic/proc_fetch.sv
// Instruction fetch unit
// Program counter, instruction register and the fetch FSM

`timescale 1ns/1ps

module proc_fetch (
  input  logic             clk,
  input  logic             reset,

  // Instruction memory request
  output logic             imem_req_val_o,
  input  logic             imem_req_rdy_i,
  output proc_pkg::addr_t  imem_req_addr_o,

  // Instruction memory response
  input  logic             imem_resp_val_i,
  output logic             imem_resp_rdy_o,
  input  proc_pkg::word_t  imem_resp_data_i,

  // To and from execute
  output proc_pkg::word_t  inst_o,
  output logic             inst_val_o,
  output proc_pkg::addr_t  pc_o,
  input  logic             retire_i,
  input  proc_pkg::addr_t  next_pc_i
);

  import proc_pkg::*;

  fetch_state_e state_q;
  addr_t        pc_q;
  word_t        inst_q;

  // ----------------------------------------
  // FSM and PC
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IREQ;
      pc_q    <= RESET_PC;
    end else begin
      case (state_q)
        IREQ: begin
          if (imem_req_rdy_i) begin
            state_q <= IWAIT;
          end
        end
        IWAIT: begin
          if (imem_resp_val_i) begin
            state_q <= EXEC;
          end
        end
        EXEC: begin
          // PC only moves once the instruction is done
          if (retire_i) begin
            state_q <= IREQ;
            pc_q    <= next_pc_i;
          end
        end
        default: state_q <= IREQ;
      endcase
    end
  end

  // Instruction register, loaded on the response transfer
  always_ff @(posedge clk) begin
    if (state_q == IWAIT && imem_resp_val_i) begin
      inst_q <= imem_resp_data_i;
    end
  end

  assign imem_req_val_o  = (state_q == IREQ);
  assign imem_req_addr_o = pc_q;
  assign imem_resp_rdy_o = (state_q == IWAIT);

  assign inst_o     = inst_q;
  assign inst_val_o = (state_q == EXEC);
  assign pc_o       = pc_q;

  // ----------------------------------------
  // Assertions
  // ----------------------------------------

  // Execute may only retire what fetch is holding
  a_retire_in_exec : assert property (@(posedge clk) disable iff (reset)
    retire_i |-> state_q == EXEC);

  // Branch targets from execute keep fetch word aligned
  a_req_aligned : assert property (@(posedge clk) disable iff (reset)
    imem_req_val_o |-> imem_req_addr_o[1:0] == 2'b00);

endmodule

//--- logic/proc_exec.sv
// Execute unit
// Decode, register file, branch resolution and manager CSR access

`timescale 1ns/1ps

module proc_exec (
  input  logic             clk,
  input  logic             reset,
  input  proc_pkg::word_t  inst_i,
  input  logic             inst_val_i,
  input  proc_pkg::addr_t  pc_i,
  output logic             retire_o,
  output proc_pkg::addr_t  next_pc_o,
  input  proc_pkg::word_t  mngr2proc_msg_i,
  input  logic             mngr2proc_val_i,
  output logic             mngr2proc_rdy_o,
  output logic             enq_val_o,
  input  logic             enq_rdy_i,
  output proc_pkg::word_t  enq_msg_o
);

  import proc_pkg::*;

  // R-type and I-type ALU ops share the funct3 map
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  logic [6:0] opcode;
  logic [2:0] funct3;
  reg_idx_t   rd, rs1, rs2;
  csr_t       csr;
  word_t      imm_i, imm_u, imm_b, shamt;
  word_t      rs1_val, rs2_val, alu_b, alu_result, wr_data;
  alu_op_e    alu_op;
  logic       alu_cond, rf_wen, is_branch, csrr_mngr, csrw_mngr;
  word_t      rf [32];

  assign opcode = inst_i[6:0];
  assign rd     = inst_i[11:7];
  assign funct3 = inst_i[14:12];
  assign rs1    = inst_i[19:15];
  assign rs2    = inst_i[24:20];
  assign csr    = inst_i[31:20];

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign shamt = {27'b0, inst_i[24:20]};

  // x0 always reads zero
  assign rs1_val = (rs1 == '0) ? '0 : rf[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : rf[rs2];

  // ----------------------------------------
  // Decode
  // ----------------------------------------

  always_comb begin
    alu_op    = ALU_ADD;
    alu_b     = rs2_val;
    rf_wen    = 1'b0;
    is_branch = 1'b0;
    csrr_mngr = 1'b0;
    csrw_mngr = 1'b0;
    case (opcode)
      OPC_OP: begin
        rf_wen = 1'b1;
        alu_op = arith_op(funct3, inst_i[30]);
      end
      OPC_OP_IMM: begin
        rf_wen = 1'b1;
        alu_op = arith_op(funct3, inst_i[30] && funct3 == 3'b101);
        alu_b  = (funct3 == 3'b001 || funct3 == 3'b101) ? shamt : imm_i;
      end
      OPC_LUI: begin
        rf_wen = 1'b1;
        alu_op = ALU_PASS_B;
        alu_b  = imm_u;
      end
      OPC_BRANCH: begin
        is_branch = 1'b1;
        case (funct3)
          3'b000:  alu_op = ALU_EQ;
          3'b001:  alu_op = ALU_NE;
          3'b100:  alu_op = ALU_LT;
          3'b101:  alu_op = ALU_GE;
          3'b110:  alu_op = ALU_LTU;
          3'b111:  alu_op = ALU_GEU;
          default: is_branch = 1'b0;
        endcase
      end
      OPC_SYSTEM: begin
        // CSRR is csrrs rd,csr,x0 and CSRW is csrrw x0,csr,rs1
        csrr_mngr = (funct3 == 3'b010) && (csr == CSR_MNGR2PROC);
        csrw_mngr = (funct3 == 3'b001) && (csr == CSR_PROC2MNGR);
        rf_wen    = csrr_mngr;
      end
      default: ;
    endcase
  end

  proc_alu i_alu (
    .op_i     (alu_op),
    .a_i      (rs1_val),
    .b_i      (alu_b),
    .result_o (alu_result),
    .cond_o   (alu_cond)
  );

  // ----------------------------------------
  // Retire, writeback and next PC
  // ----------------------------------------

  assign mngr2proc_rdy_o = inst_val_i && csrr_mngr;
  assign enq_val_o       = inst_val_i && csrw_mngr;
  assign enq_msg_o       = rs1_val;

  // Hold in EXEC while either manager side back-pressures
  assign retire_o = inst_val_i && !(csrr_mngr && !mngr2proc_val_i)
                               && !(csrw_mngr && !enq_rdy_i);

  assign next_pc_o = (is_branch && alu_cond) ? pc_i + imm_b : pc_i + 32'd4;
  assign wr_data   = csrr_mngr ? mngr2proc_msg_i : alu_result;

  always_ff @(posedge clk) begin
    if (retire_o && rf_wen && rd != '0) begin
      rf[rd] <= wr_data;
    end
  end

  // A stalled instruction stays in place with its PC until it retires
  a_stall_holds : assert property (@(posedge clk) disable iff (reset)
    inst_val_i && !retire_o |=> inst_val_i && $stable(pc_i) && $stable(inst_i));

endmodule

//--- logic/proc_out_queue.sv
// One-entry bypass queue toward the manager

`timescale 1ns/1ps

module proc_out_queue (
  input  logic             clk,
  input  logic             reset,
  input  logic             enq_val_i,
  output logic             enq_rdy_o,
  input  proc_pkg::word_t  enq_msg_i,
  output logic             deq_val_o,
  input  logic             deq_rdy_i,
  output proc_pkg::word_t  deq_msg_o
);

  import proc_pkg::*;

  logic  full_q;
  word_t data_q;
  logic  store;

  // Word is kept only when it cannot leave this cycle
  assign store = enq_val_i && !full_q && !deq_rdy_i;

  always_ff @(posedge clk) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (store) begin
      full_q <= 1'b1;
    end else if (full_q && deq_rdy_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (store) begin
      data_q <= enq_msg_i;
    end
  end

  assign enq_rdy_o = !full_q;
  assign deq_val_o = full_q || enq_val_i;
  assign deq_msg_o = full_q ? data_q : enq_msg_i;

  // A word offered while full waits unchanged until there is room
  a_no_enq_when_full : assert property (@(posedge clk) disable iff (reset)
    enq_val_i && full_q |=> enq_val_i && $stable(enq_msg_i));

endmodule

//--- logic/proc_top.sv
// Core top level
// Connects fetch, execute and the manager output queue

`timescale 1ns/1ps

module proc_top (
  input  logic             clk,
  input  logic             reset,

  // Instruction memory
  output logic             imem_req_val_o,
  input  logic             imem_req_rdy_i,
  output proc_pkg::addr_t  imem_req_addr_o,
  input  logic             imem_resp_val_i,
  output logic             imem_resp_rdy_o,
  input  proc_pkg::word_t  imem_resp_data_i,

  // Manager streams
  input  proc_pkg::word_t  mngr2proc_msg_i,
  input  logic             mngr2proc_val_i,
  output logic             mngr2proc_rdy_o,
  output proc_pkg::word_t  proc2mngr_msg_o,
  output logic             proc2mngr_val_o,
  input  logic             proc2mngr_rdy_i
);

  import proc_pkg::*;

  word_t inst;
  logic  inst_val;
  addr_t pc;
  logic  retire;
  addr_t next_pc;
  logic  enq_val;
  logic  enq_rdy;
  word_t enq_msg;

  proc_fetch i_fetch (
    .clk              (clk),
    .reset            (reset),
    .imem_req_val_o   (imem_req_val_o),
    .imem_req_rdy_i   (imem_req_rdy_i),
    .imem_req_addr_o  (imem_req_addr_o),
    .imem_resp_val_i  (imem_resp_val_i),
    .imem_resp_rdy_o  (imem_resp_rdy_o),
    .imem_resp_data_i (imem_resp_data_i),
    .inst_o           (inst),
    .inst_val_o       (inst_val),
    .pc_o             (pc),
    .retire_i         (retire),
    .next_pc_i        (next_pc)
  );

  proc_exec i_exec (
    .clk             (clk),
    .reset           (reset),
    .inst_i          (inst),
    .inst_val_i      (inst_val),
    .pc_i            (pc),
    .retire_o        (retire),
    .next_pc_o       (next_pc),
    .mngr2proc_msg_i (mngr2proc_msg_i),
    .mngr2proc_val_i (mngr2proc_val_i),
    .mngr2proc_rdy_o (mngr2proc_rdy_o),
    .enq_val_o       (enq_val),
    .enq_rdy_i       (enq_rdy),
    .enq_msg_o       (enq_msg)
  );

  proc_out_queue i_out_queue (
    .clk       (clk),
    .reset     (reset),
    .enq_val_i (enq_val),
    .enq_rdy_o (enq_rdy),
    .enq_msg_i (enq_msg),
    .deq_val_o (proc2mngr_val_o),
    .deq_rdy_i (proc2mngr_rdy_i),
    .deq_msg_o (proc2mngr_msg_o)
  );

endmodule

//--- tb/proc_tb.sv
// Testbench for the core top level
// Clock, reset, instruction memory model, manager source and sink
// Directed test tasks with typed compare tasks

`timescale 1ns/1ps

module proc_tb;

  import proc_pkg::*;

  localparam int MEM_WORDS     = 64;
  localparam int RESET_CYCLES  = 16;
  localparam int SETTLE_CYCLES = 20;
  localparam int NUM_TESTS     = 6;
  // Dynamic instruction counts of reset, echo, reg ALU, imm, branch and echo again
  localparam int TOTAL_INSTS   = 6 + 11 + 25 + 22 + 52 + 11;
  localparam int TIMEOUT_CYCLES =
    2 * (TOTAL_INSTS * 8 + NUM_TESTS * (RESET_CYCLES + SETTLE_CYCLES + 2));

  logic  clk;
  logic  reset;
  logic  imem_req_val_o;
  logic  imem_req_rdy_i;
  addr_t imem_req_addr_o;
  logic  imem_resp_val_i;
  logic  imem_resp_rdy_o;
  word_t imem_resp_data_i;
  word_t mngr2proc_msg_i;
  logic  mngr2proc_val_i;
  logic  mngr2proc_rdy_o;
  word_t proc2mngr_msg_o;
  logic  proc2mngr_val_o;
  logic  proc2mngr_rdy_i;

  word_t mem [MEM_WORDS];
  word_t prog[$];
  word_t in_words[$];
  word_t src_q[$];
  word_t out_q[$];
  word_t exp_q[$];
  addr_t req_log[$];

  integer seed = 3301;
  logic   rand_mode;
  logic   mem_busy;
  addr_t  mem_addr;
  int     mem_delay;
  int     cycles;
  int     checks;
  int     errors;

  proc_top i_dut (
    .clk              (clk),
    .reset            (reset),
    .imem_req_val_o   (imem_req_val_o),
    .imem_req_rdy_i   (imem_req_rdy_i),
    .imem_req_addr_o  (imem_req_addr_o),
    .imem_resp_val_i  (imem_resp_val_i),
    .imem_resp_rdy_o  (imem_resp_rdy_o),
    .imem_resp_data_i (imem_resp_data_i),
    .mngr2proc_msg_i  (mngr2proc_msg_i),
    .mngr2proc_val_i  (mngr2proc_val_i),
    .mngr2proc_rdy_o  (mngr2proc_rdy_o),
    .proc2mngr_msg_o  (proc2mngr_msg_o),
    .proc2mngr_val_o  (proc2mngr_val_o),
    .proc2mngr_rdy_i  (proc2mngr_rdy_i)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ----------------------------------------
  // Environment models
  // ----------------------------------------

  // Instruction memory serving one request at a time after 0 to 2 cycles of delay
  always @(posedge clk) begin
    if (reset) begin
      imem_req_rdy_i  <= 1'b1;
      imem_resp_val_i <= 1'b0;
      mem_busy        <= 1'b0;
    end else if (!mem_busy) begin
      if (imem_req_val_o && imem_req_rdy_i) begin
        req_log.push_back(imem_req_addr_o);
        mem_busy       <= 1'b1;
        mem_addr       <= imem_req_addr_o;
        mem_delay      <= rand_mode ? $unsigned($random(seed)) % 3 : 0;
        imem_req_rdy_i <= 1'b0;
      end
    end else if (imem_resp_val_i) begin
      if (imem_resp_rdy_o) begin
        imem_resp_val_i <= 1'b0;
        mem_busy        <= 1'b0;
        imem_req_rdy_i  <= 1'b1;
      end
    end else if (mem_delay == 0) begin
      imem_resp_val_i  <= 1'b1;
      imem_resp_data_i <= mem[(mem_addr - RESET_PC) >> 2];
    end else begin
      mem_delay <= mem_delay - 1;
    end
  end

  // Manager source holds a word until it is taken
  always @(posedge clk) begin
    if (reset) begin
      mngr2proc_val_i <= 1'b0;
    end else if (!mngr2proc_val_i || mngr2proc_rdy_o) begin
      if (mngr2proc_val_i) begin
        void'(src_q.pop_front());
      end
      if (src_q.size() > 0 && (!rand_mode || ($random(seed) % 2) != 0)) begin
        mngr2proc_val_i <= 1'b1;
        mngr2proc_msg_i <= src_q[0];
      end else begin
        mngr2proc_val_i <= 1'b0;
      end
    end
  end

  // Manager sink
  always @(posedge clk) begin
    if (reset) begin
      proc2mngr_rdy_i <= 1'b0;
    end else begin
      if (proc2mngr_val_o && proc2mngr_rdy_i) begin
        out_q.push_back(proc2mngr_msg_o);
      end
      proc2mngr_rdy_i <= rand_mode ? (($random(seed) % 2) != 0) : 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // Instruction encoders
  // ----------------------------------------

  function automatic word_t enc_r(input logic [2:0] f3, input logic alt,
                                  input reg_idx_t rd, input reg_idx_t rs1,
                                  input reg_idx_t rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t enc_i(input logic [2:0] f3, input reg_idx_t rd,
                                  input reg_idx_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic word_t enc_b(input logic [2:0] f3, input reg_idx_t rs1,
                                  input reg_idx_t rs2, input int off);
    logic [12:0] o;
    o = off[12:0];
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_csrr(input reg_idx_t rd);
    return {CSR_MNGR2PROC, 5'd0, 3'b010, rd, OPC_SYSTEM};
  endfunction

  function automatic word_t enc_csrw(input reg_idx_t rs1);
    return {CSR_PROC2MNGR, rs1, 3'b001, 5'd0, OPC_SYSTEM};
  endfunction

  // ----------------------------------------
  // Expected results from RV32 rules
  // ----------------------------------------

  function automatic word_t rv32_op(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic rv32_taken(input logic [2:0] f3, input word_t a,
                                      input word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------
  // Program and run helpers
  // ----------------------------------------

  function automatic void emit(input word_t w);
    prog.push_back(w);
  endfunction

  function automatic void new_test();
    prog.delete();
    in_words.delete();
    exp_q.delete();
  endfunction

  // Reset the core with the program loaded and the inputs queued
  task automatic start_program();
    addr_t a;
    @(posedge clk);
    reset <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < MEM_WORDS; i++) begin
      a = RESET_PC + 4 * i;
      // Unused slots are no-ops tagged with their address
      mem[i] = (i < prog.size()) ? prog[i] : enc_i(3'd0, 5'd0, 5'd0, a[11:0]);
    end
    src_q = in_words;
    req_log.delete();
    out_q.delete();
    repeat (RESET_CYCLES - 1) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic run_and_compare(input string name);
    start_program();
    while (out_q.size() < exp_q.size()) @(negedge clk);
    repeat (SETTLE_CYCLES) @(negedge clk);
    checks++;
    if (out_q.size() != exp_q.size()) begin
      errors++;
      $display("%s: expected %0d output words but the manager received %0d",
               name, exp_q.size(), out_q.size());
    end
    foreach (exp_q[i]) begin
      check_word(out_q[i], exp_q[i], $sformatf("%s output %0d", name, i));
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------

  task automatic test_reset();
    new_test();
    repeat (4) emit(enc_i(3'd0, 5'd0, 5'd0, 12'd0));
    emit(enc_b(3'd0, 5'd0, 5'd0, 0));
    start_program();
    @(negedge clk);
    check_bit(proc2mngr_val_o, 1'b0, "proc2mngr_val_o after reset");
    check_bit(mngr2proc_rdy_o, 1'b0, "mngr2proc_rdy_o after reset");
    check_bit(imem_resp_rdy_o, 1'b0, "imem_resp_rdy_o after reset");
    check_bit(imem_req_val_o, 1'b1, "imem_req_val_o after reset");
    while (req_log.size() < 6) @(negedge clk);
    for (int i = 0; i < 5; i++) begin
      check_addr(req_log[i], RESET_PC + 4 * i, $sformatf("fetch address %0d", i));
    end
    // Branch to itself refetches the same word
    check_addr(req_log[5], RESET_PC + 16, "self loop refetch address");
  endtask

  task automatic test_echo();
    word_t w;
    new_test();
    for (int i = 0; i < 5; i++) begin
      w = $random(seed);
      in_words.push_back(w);
      exp_q.push_back(w);
      emit(enc_csrr(5'd1));
      emit(enc_csrw(5'd1));
    end
    emit(enc_b(3'd0, 5'd0, 5'd0, 0));
    run_and_compare("echo");
  endtask

  task automatic test_reg_alu();
    word_t      a;
    word_t      b;
    logic [2:0] f3;
    logic       alt;
    new_test();
    a = 32'h8000_7F35;
    b = 32'h0000_1234;
    in_words.push_back(a);
    in_words.push_back(b);
    emit(enc_csrr(5'd1));
    emit(enc_csrr(5'd2));
    // funct3 0 to 7 followed by SUB and SRA
    for (int i = 0; i < 10; i++) begin
      f3  = (i < 8) ? i[2:0] : ((i == 8) ? 3'd0 : 3'd5);
      alt = (i >= 8);
      emit(enc_r(f3, alt, 5'd3, 5'd1, 5'd2));
      emit(enc_csrw(5'd3));
      exp_q.push_back(rv32_op(f3, alt, a, b));
    end
    emit(enc_r(3'd0, 1'b0, 5'd0, 5'd1, 5'd2));
    emit(enc_csrw(5'd0));
    exp_q.push_back(32'd0);
    emit(enc_b(3'd0, 5'd0, 5'd0, 0));
    run_and_compare("reg alu");
  endtask

  task automatic imm_case(input logic [2:0] f3, input word_t a, input logic [11:0] imm);
    emit(enc_i(f3, 5'd3, 5'd1, imm));
    emit(enc_csrw(5'd3));
    exp_q.push_back(rv32_op(f3, f3 == 3'd5 && imm[10], a, {{20{imm[11]}}, imm}));
  endtask

  task automatic test_imm();
    word_t a;
    new_test();
    a = 32'h8765_4321;
    in_words.push_back(a);
    emit(enc_csrr(5'd1));
    imm_case(3'd0, a, 12'hFFB);
    imm_case(3'd2, a, 12'h005);
    imm_case(3'd3, a, 12'hFFF);
    imm_case(3'd4, a, 12'h80F);
    imm_case(3'd6, a, 12'h0F0);
    imm_case(3'd7, a, 12'h7F0);
    imm_case(3'd1, a, 12'h007);
    imm_case(3'd5, a, 12'h004);
    imm_case(3'd5, a, 12'h404);
    emit({20'hABCDE, 5'd4, OPC_LUI});
    emit(enc_csrw(5'd4));
    exp_q.push_back({20'hABCDE, 12'h000});
    emit(enc_b(3'd0, 5'd0, 5'd0, 0));
    run_and_compare("immediate");
  endtask

  // Writes the taken marker 0x100+idx or the not-taken marker 0x200+idx
  task automatic br_case(input logic [2:0] f3, input reg_idx_t rs1, input word_t a,
                         input reg_idx_t rs2, input word_t b, input int idx);
    emit(enc_b(f3, rs1, rs2, 12));
    emit(enc_i(3'd0, 5'd5, 5'd0, 12'h200 + idx));
    emit(enc_b(3'd0, 5'd0, 5'd0, 8));
    emit(enc_i(3'd0, 5'd5, 5'd0, 12'h100 + idx));
    emit(enc_csrw(5'd5));
    exp_q.push_back(rv32_taken(f3, a, b) ? 32'h100 + idx : 32'h200 + idx);
  endtask

  task automatic test_branch();
    new_test();
    // Counting loop on BNE
    emit(enc_i(3'd0, 5'd1, 5'd0, 12'd0));
    emit(enc_i(3'd0, 5'd2, 5'd0, 12'd4));
    emit(enc_i(3'd0, 5'd1, 5'd1, 12'd1));
    emit(enc_csrw(5'd1));
    emit(enc_b(3'd1, 5'd1, 5'd2, -8));
    for (int k = 1; k <= 4; k++) begin
      exp_q.push_back(k);
    end
    // x3 is -1 and x4 is 1
    emit(enc_i(3'd0, 5'd3, 5'd0, 12'hFFF));
    emit(enc_i(3'd0, 5'd4, 5'd0, 12'd1));
    br_case(3'd0, 5'd4, 32'd1, 5'd4, 32'd1, 0);
    br_case(3'd0, 5'd3, '1, 5'd4, 32'd1, 1);
    br_case(3'd4, 5'd3, '1, 5'd4, 32'd1, 2);
    br_case(3'd4, 5'd4, 32'd1, 5'd3, '1, 3);
    br_case(3'd5, 5'd4, 32'd1, 5'd3, '1, 4);
    br_case(3'd5, 5'd3, '1, 5'd4, 32'd1, 5);
    br_case(3'd6, 5'd4, 32'd1, 5'd3, '1, 6);
    br_case(3'd6, 5'd3, '1, 5'd4, 32'd1, 7);
    br_case(3'd7, 5'd3, '1, 5'd4, 32'd1, 8);
    br_case(3'd7, 5'd0, 32'd0, 5'd4, 32'd1, 9);
    emit(enc_b(3'd0, 5'd0, 5'd0, 0));
    run_and_compare("branch");
  endtask

  task automatic test_backpressure();
    rand_mode = 1'b1;
    test_echo();
    rand_mode = 1'b0;
  endtask

  initial begin
    reset            = 1'b1;
    imem_req_rdy_i   = 1'b0;
    imem_resp_val_i  = 1'b0;
    imem_resp_data_i = '0;
    mngr2proc_msg_i  = '0;
    mngr2proc_val_i  = 1'b0;
    proc2mngr_rdy_i  = 1'b0;
    rand_mode        = 1'b0;
    cycles           = 0;
    checks           = 0;
    errors           = 0;
    test_reset();
    test_echo();
    test_reg_alu();
    test_imm();
    test_branch();
    test_backpressure();
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
logic/proc_pkg.sv
logic/proc_alu.sv
logic/proc_fetch.sv
logic/proc_exec.sv
logic/proc_out_queue.sv
logic/proc_top.sv
tb/proc_tb.sv

//--- Bender.yml
package:
  name: tinyrv2_proc

sources:
  - logic/proc_pkg.sv
  - logic/proc_alu.sv
  - logic/proc_fetch.sv
  - logic/proc_exec.sv
  - logic/proc_out_queue.sv
  - logic/proc_top.sv
  - target: test
    files:
      - tb/proc_tb.sv
